//--- flist.f
+incdir+src
src/wave_pkg.sv
src/link_pkg.sv
src/prog_if.sv
src/uart_rx.sv
src/packet_parser.sv
src/program_store.sv
src/step_sequencer.sv
src/vector_engine.sv
src/image_wave_gen.sv
verification/image_wave_gen_assertions.sv
verification/image_wave_gen_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := image_wave_gen_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/image_wave_gen_tb.sv
// testbench with clock, reset, uart byte driver, program table and landmark checks
`timescale 1ns/1ps
`default_nettype none

`include "wave_consts.svh"

module image_wave_gen_tb;
    localparam int CLKS_PER_BIT = `CLK_FREQ / `BAUD;
    localparam int SLOT_TIMEOUT = 1000;
    localparam int LOAD_TIMEOUT = 400;

    typedef struct packed {
        wave_pkg::opcode_e x_op;
        logic [7:0]        xa;
        logic [7:0]        xb;
        wave_pkg::opcode_e y_op;
        logic [7:0]        ya;
        logic [7:0]        yb;
        logic [7:0]        x_land;     // dac value when the slot ends
        logic [7:0]        y_land;
        logic [7:0]        x_peak;     // only checked on rect rows
        logic [7:0]        y_peak;
    } slot_row_t;

    logic       clk;
    logic       reset;
    logic       enable;
    logic       uart_line;
    logic [7:0] xdac;
    logic [7:0] ydac;
    logic       program_loaded;
    logic       engine_ack;
    logic       x_done;
    logic       y_done;
    int         mismatches;
    int         timeouts;

    // x op, a, b, y op, a, b, x end, y end, x peak, y peak
    slot_row_t rows [`PROG_DEPTH] = '{
        '{wave_pkg::op_jump,   8'd40, 8'd0,  wave_pkg::op_jump,   8'd100, 8'd0,
          8'd40,  8'd100, 8'd0,   8'd0},
        '{wave_pkg::op_incr,   8'd30, 8'd0,  wave_pkg::op_dcre,   8'd20,  8'd0,
          8'd70,  8'd80,  8'd0,   8'd0},
        '{wave_pkg::op_line,   8'd10, 8'd50, wave_pkg::op_line,   8'd200, 8'd150,
          8'd50,  8'd150, 8'd0,   8'd0},
        '{wave_pkg::op_x_rect, 8'd20, 8'd5,  wave_pkg::op_y_rect, 8'd4,   8'd30,
          8'd50,  8'd150, 8'd70,  8'd180},
        '{wave_pkg::op_nop,    8'd0,  8'd0,  wave_pkg::op_incr,   8'd10,  8'd0,
          8'd50,  8'd160, 8'd0,   8'd0},
        '{wave_pkg::op_dcre,   8'd60, 8'd0,  wave_pkg::op_nop,    8'd0,   8'd0,
          8'd246, 8'd160, 8'd0,   8'd0},   // x wraps below zero
        '{wave_pkg::op_y_rect, 8'd3,  8'd8,  wave_pkg::op_x_rect, 8'd50,  8'd2,
          8'd246, 8'd160, 8'd254, 8'd210},
        '{wave_pkg::op_incr,   8'd14, 8'd0,  wave_pkg::op_line,   8'd20,  8'd0,
          8'd4,   8'd0,   8'd0,   8'd0}    // x wraps past 255
    };

    image_wave_gen image_wave_gen_inst (
        .clk(clk), .reset(reset), .enable(enable), .uart_rx(uart_line),
        .xdac(xdac), .ydac(ydac), .program_loaded(program_loaded)
    );

    bind vector_engine image_wave_gen_assertions assertions_inst (
        .clk(clk), .reset(reset), .enable(enable), .ack(ack),
        .x_done(x_done), .y_done(y_done), .xdac(xdac), .ydac(ydac)
    );

    // slot boundary signals inside the engine
    assign engine_ack = image_wave_gen_inst.vector_engine_inst.ack;
    assign x_done     = image_wave_gen_inst.vector_engine_inst.x_done;
    assign y_done     = image_wave_gen_inst.vector_engine_inst.y_done;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // checks

    task automatic check_value(input string what, input logic [7:0] got,
                               input logic [7:0] expected);
        assert (got == expected) else begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            mismatches++;
        end
    endtask

    task automatic check_step(input string what, input logic [7:0] prev, input logic [7:0] now);
        int diff;
        diff = int'(now) - int'(prev);
        assert (diff >= -1 && diff <= 1) else begin
            $display("mismatch at %0t: %s jumped from %0d to %0d", $time, what, prev, now);
            mismatches++;
        end
    endtask

    //////////////////////////////////////////////////
    // 8N1 uart driver sending lsb first

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        repeat (10) begin
            @(posedge clk);
            uart_line <= frame[0];
            frame = frame >> 1;
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_packet(input logic [2:0] field, input logic [8*`PROG_DEPTH-1:0] data,
                               input logic [7:0] end_byte);
        logic [8*`PROG_DEPTH-1:0] rest;
        rest = data;
        send_byte(`SYNC_BYTE);
        send_byte({5'd0, field});
        repeat (`PROG_DEPTH) begin
            send_byte(rest[7:0]);     // slot 0 first
            rest = rest >> 8;
        end
        send_byte(end_byte);
    endtask

    // one packet payload from a table column
    function automatic logic [8*`PROG_DEPTH-1:0] field_bytes(input link_pkg::field_sel_e field);
        logic [8*`PROG_DEPTH-1:0] v;
        logic [7:0]               b;
        v = '0;
        for (int k = 0; k < `PROG_DEPTH; k++) begin
            case (field)
                link_pkg::fs_x_op: b = {5'b10110, rows[3'(k)].x_op};  // pad bits are ignored
                link_pkg::fs_x_a:  b = rows[3'(k)].xa;
                link_pkg::fs_x_b:  b = rows[3'(k)].xb;
                link_pkg::fs_y_op: b = {5'b01001, rows[3'(k)].y_op};
                link_pkg::fs_y_a:  b = rows[3'(k)].ya;
                link_pkg::fs_y_b:  b = rows[3'(k)].yb;
                default:           b = 8'hff;
            endcase
            v = {b, v[8*`PROG_DEPTH-1:8]};
        end
        return v;
    endfunction

    task automatic wait_loaded();
        int cycles;
        cycles = 0;
        while (!program_loaded && cycles < LOAD_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!program_loaded) begin
            $display("timeout: program_loaded never rose after the program packets");
            timeouts++;
        end
    endtask

    //////////////////////////////////////////////////
    // one slot watched cycle by cycle until the engine acks

    task automatic run_slot(input logic [2:0] slot);
        slot_row_t  r;
        logic [7:0] x_prev;
        logic [7:0] y_prev;
        logic [7:0] x_max;
        logic [7:0] y_max;
        bit         x_seen_a;
        bit         y_seen_a;
        int         cycles;
        r        = rows[slot];
        x_prev   = xdac;
        y_prev   = ydac;
        x_max    = xdac;
        y_max    = ydac;
        x_seen_a = 1'b0;
        y_seen_a = 1'b0;
        cycles   = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (r.x_op == wave_pkg::op_line) begin
                if (x_seen_a) check_step($sformatf("slot %0d xdac", slot), x_prev, xdac);
                if (xdac == r.xa) x_seen_a = 1'b1;
            end
            if (r.y_op == wave_pkg::op_line) begin
                if (y_seen_a) check_step($sformatf("slot %0d ydac", slot), y_prev, ydac);
                if (ydac == r.ya) y_seen_a = 1'b1;
            end
            // a finished channel waits on its landmark
            if (x_done && !engine_ack)
                check_value($sformatf("held xdac %0d", slot), xdac, r.x_land);
            if (y_done && !engine_ack)
                check_value($sformatf("held ydac %0d", slot), ydac, r.y_land);
            if (xdac > x_max) x_max = xdac;
            if (ydac > y_max) y_max = ydac;
            x_prev = xdac;
            y_prev = ydac;
        end while (!engine_ack && cycles < SLOT_TIMEOUT);

        if (!engine_ack) begin
            $display("timeout: slot %0d did not finish within %0d cycles", slot, SLOT_TIMEOUT);
            timeouts++;
        end else begin
            check_value($sformatf("slot %0d xdac", slot), xdac, r.x_land);
            check_value($sformatf("slot %0d ydac", slot), ydac, r.y_land);
            if (r.x_op == wave_pkg::op_x_rect || r.x_op == wave_pkg::op_y_rect)
                check_value($sformatf("slot %0d x peak", slot), x_max, r.x_peak);
            if (r.y_op == wave_pkg::op_x_rect || r.y_op == wave_pkg::op_y_rect)
                check_value($sformatf("slot %0d y peak", slot), y_max, r.y_peak);
            if (r.x_op == wave_pkg::op_line)
                check_value($sformatf("slot %0d x passed a", slot), {7'd0, x_seen_a}, 8'd1);
            if (r.y_op == wave_pkg::op_line)
                check_value($sformatf("slot %0d y passed a", slot), {7'd0, y_seen_a}, 8'd1);
        end
    endtask

    // drop enable mid-slot and expect both dacs to stand still
    task automatic freeze_check();
        logic [7:0] x_hold;
        logic [7:0] y_hold;
        repeat (5) @(negedge clk);
        @(posedge clk);
        enable <= 1'b0;
        @(negedge clk);
        x_hold = xdac;
        y_hold = ydac;
        repeat (10) begin
            @(negedge clk);
            check_value("frozen xdac", xdac, x_hold);
            check_value("frozen ydac", ydac, y_hold);
        end
        @(posedge clk);
        enable <= 1'b1;
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        reset      = 1'b1;
        enable     = 1'b0;
        uart_line  = 1'b1;
        mismatches = 0;
        timeouts   = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("xdac after reset", xdac, 8'd0);
        check_value("ydac after reset", ydac, 8'd0);
        check_value("program_loaded after reset", {7'd0, program_loaded}, 8'd0);

        // bad end byte gives no commit
        send_packet(link_pkg::fs_x_op, {`PROG_DEPTH{8'h04}}, 8'h00);
        repeat (40) @(negedge clk);
        check_value("program_loaded after bad end", {7'd0, program_loaded}, 8'd0);

        send_packet(link_pkg::fs_x_op, field_bytes(link_pkg::fs_x_op), `END_BYTE);
        send_packet(link_pkg::fs_x_a, field_bytes(link_pkg::fs_x_a), `END_BYTE);
        send_packet(link_pkg::fs_x_b, field_bytes(link_pkg::fs_x_b), `END_BYTE);
        send_packet(link_pkg::fs_y_op, field_bytes(link_pkg::fs_y_op), `END_BYTE);
        send_packet(link_pkg::fs_y_a, field_bytes(link_pkg::fs_y_a), `END_BYTE);
        send_packet(link_pkg::fs_y_b, field_bytes(link_pkg::fs_y_b), `END_BYTE);
        wait_loaded();
        send_packet(3'd7, {`PROG_DEPTH{8'hff}}, `END_BYTE);   // unused field code writes nothing
        repeat (40) @(negedge clk);

        if (timeouts == 0) begin
            @(posedge clk);
            enable <= 1'b1;
            // two extra slots show the pointer wrap
            for (int i = 0; i < `PROG_DEPTH + 2 && timeouts == 0; i++) begin
                run_slot(3'(i % `PROG_DEPTH));
                if (i == 0) freeze_check();
            end
        end

        $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/image_wave_gen_assertions.sv
// concurrent checks on the vector engine: lockstep ack and dac freeze
`timescale 1ns/1ps
`default_nettype none

module image_wave_gen_assertions (
    input logic       clk,
    input logic       reset,
    input logic       enable,
    input logic       ack,
    input logic       x_done,
    input logic       y_done,
    input logic [7:0] xdac,
    input logic [7:0] ydac
);

    // ack only follows a cycle where both channels were done
    ack_after_both_done: assert property (
        @(posedge clk) disable iff (reset) ack |-> $past(x_done && y_done)
    ) else $error("ack raised without both channels done");

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset) ack |=> !ack
    ) else $error("ack held high for two cycles");

    // no step is taken on an edge with enable low
    dac_frozen: assert property (
        @(posedge clk) disable iff (reset) !enable |=> ($stable(xdac) && $stable(ydac))
    ) else $error("dac moved while enable was low");

endmodule

`default_nettype wire

//--- src/image_wave_gen.sv
// top level: uart receiver, packet parser, program store and vector engine
`timescale 1ns/1ps
`default_nettype none

module image_wave_gen (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic       uart_rx,          // serial line, idle high
    output logic [7:0] xdac,
    output logic [7:0] ydac,
    output logic       program_loaded
);
    logic       byte_valid;
    logic [7:0] byte_data;

    prog_write_if wr_bus ();
    prog_read_if  x_rd_bus ();
    prog_read_if  y_rd_bus ();

    //////////////////////////////////////////////////
    // producer

    uart_rx uart_rx_inst (
        .clk(clk), .reset(reset), .rx(uart_rx),
        .byte_valid(byte_valid), .byte_data(byte_data)
    );

    packet_parser packet_parser_inst (
        .clk(clk), .reset(reset),
        .byte_valid(byte_valid), .byte_data(byte_data), .wr(wr_bus.writer)
    );

    // buffer and consumer
    program_store program_store_inst (
        .clk(clk), .reset(reset), .wr(wr_bus.store),
        .x_rd(x_rd_bus.store), .y_rd(y_rd_bus.store), .program_loaded(program_loaded)
    );

    vector_engine vector_engine_inst (
        .clk(clk), .reset(reset), .enable(enable),
        .x_rd(x_rd_bus.engine), .y_rd(y_rd_bus.engine), .xdac(xdac), .ydac(ydac)
    );

endmodule

`default_nettype wire

//--- src/vector_engine.sv
// vector engine: shared instruction pointer, lockstep ack, x and y step sequencers
`timescale 1ns/1ps
`default_nettype none

`include "wave_consts.svh"

module vector_engine (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    prog_read_if.engine x_rd,
    prog_read_if.engine y_rd,
    output logic [7:0]  xdac,
    output logic [7:0]  ydac
);
    localparam int IDX_W = $clog2(`PROG_DEPTH);

    logic [IDX_W-1:0] ptr;
    logic             ack;
    logic             x_done;
    logic             y_done;
    logic             advance;

    // both channels finished, ack once
    assign advance = enable && x_done && y_done && !ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
            ack <= 1'b0;
        end else begin
            ack <= advance;
            if (advance) ptr <= (ptr == IDX_W'(`PROG_DEPTH - 1)) ? '0 : ptr + 1'b1;
        end
    end

    assign x_rd.index = ptr;
    assign y_rd.index = ptr;

    step_sequencer x_seq (
        .clk(clk), .reset(reset), .enable(enable), .ack(ack),
        .opcode(x_rd.opcode), .param_a(x_rd.param_a), .param_b(x_rd.param_b),
        .dac(xdac), .done(x_done)
    );

    step_sequencer y_seq (
        .clk(clk), .reset(reset), .enable(enable), .ack(ack),
        .opcode(y_rd.opcode), .param_a(y_rd.param_a), .param_b(y_rd.param_b),
        .dac(ydac), .done(y_done)
    );

endmodule

`default_nettype wire

//--- src/step_sequencer.sv
// step sequencer: one dac channel executing one instruction slot at a time
`timescale 1ns/1ps
`default_nettype none

module step_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic              ack,
    input  wave_pkg::opcode_e opcode,
    input  logic [7:0]        param_a,
    input  logic [7:0]        param_b,
    output logic [7:0]        dac,
    output logic              done
);
    logic [7:0]       cnt;       // channel counter, drives the dac
    wave_pkg::phase_e phase;
    logic [7:0]       steps;     // steps taken in the current phase
    logic [7:0]       limit;
    wave_pkg::phase_e last_ph;
    logic             step_up;
    logic             step_down;

    //////////////////////////////////////////////////
    // per-phase direction and length for the counted instructions

    always_comb begin
        step_up   = 1'b0;
        step_down = 1'b0;
        limit     = param_a;
        last_ph   = wave_pkg::ph_0;
        case (opcode)
            wave_pkg::op_incr: step_up   = 1'b1;
            wave_pkg::op_dcre: step_down = 1'b1;
            wave_pkg::op_x_rect: begin   // up a, hold b, down a, hold b
                last_ph   = wave_pkg::ph_3;
                if (phase[0]) limit = param_b;
                step_up   = (phase == wave_pkg::ph_0);
                step_down = (phase == wave_pkg::ph_2);
            end
            wave_pkg::op_y_rect: begin   // hold a, up b, hold a, down b
                last_ph   = wave_pkg::ph_3;
                if (phase[0]) limit = param_b;
                step_up   = (phase == wave_pkg::ph_1);
                step_down = (phase == wave_pkg::ph_3);
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // one step per enabled clock

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt   <= '0;
            phase <= wave_pkg::ph_0;
            steps <= '0;
        end else if (ack) begin
            // taken even with enable low, the engine only acks while enabled
            phase <= wave_pkg::ph_0;
            steps <= '0;
        end else if (enable && phase != wave_pkg::ph_done) begin
            case (opcode)
                wave_pkg::op_jump: begin
                    cnt   <= param_a;
                    phase <= wave_pkg::ph_done;
                end
                wave_pkg::op_line: begin
                    if (phase == wave_pkg::ph_0) begin
                        cnt   <= param_a;       // load start point
                        phase <= wave_pkg::ph_1;
                    end else if (cnt == param_b) begin
                        phase <= wave_pkg::ph_done;
                    end else if (cnt < param_b) begin
                        cnt <= cnt + 8'd1;
                    end else begin
                        cnt <= cnt - 8'd1;
                    end
                end
                wave_pkg::op_incr, wave_pkg::op_dcre,
                wave_pkg::op_x_rect, wave_pkg::op_y_rect: begin
                    if (steps == limit) begin
                        steps <= '0;
                        phase <= (phase == last_ph) ? wave_pkg::ph_done
                                                    : wave_pkg::phase_e'(phase + 3'd1);
                    end else begin
                        steps <= steps + 8'd1;
                        if (step_up)        cnt <= cnt + 8'd1;  // wraps at 255
                        else if (step_down) cnt <= cnt - 8'd1;
                    end
                end
                default: phase <= wave_pkg::ph_done;  // nop holds the counter
            endcase
        end
    end

    assign dac  = cnt;
    assign done = (phase == wave_pkg::ph_done);

endmodule

`default_nettype wire

//--- src/program_store.sv
// program store: per-channel opcode and parameter slots, loaded flag, two read ports
`timescale 1ns/1ps
`default_nettype none

`include "wave_consts.svh"

module program_store (
    input  logic        clk,
    input  logic        reset,
    prog_write_if.store wr,
    prog_read_if.store  x_rd,
    prog_read_if.store  y_rd,
    output logic        program_loaded
);
    wave_pkg::opcode_e    x_op [`PROG_DEPTH];
    wave_pkg::opcode_e    y_op [`PROG_DEPTH];
    logic [7:0]           x_a  [`PROG_DEPTH];
    logic [7:0]           x_b  [`PROG_DEPTH];
    logic [7:0]           y_a  [`PROG_DEPTH];
    logic [7:0]           y_b  [`PROG_DEPTH];
    wave_pkg::prog_byte_u wr_byte;

    assign wr_byte = wr.data;   // opcode fields take the low three bits

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PROG_DEPTH; i++) begin
                x_op[i] <= wave_pkg::op_nop;
                y_op[i] <= wave_pkg::op_nop;
                x_a[i]  <= '0;
                x_b[i]  <= '0;
                y_a[i]  <= '0;
                y_b[i]  <= '0;
            end
            program_loaded <= 1'b0;
        end else begin
            if (wr.commit) program_loaded <= 1'b1;  // sticky until reset
            if (wr.wr_en) begin
                case (wr.field)
                    link_pkg::fs_x_op: x_op[wr.index] <= wr_byte.instr.op;
                    link_pkg::fs_x_a:  x_a[wr.index]  <= wr_byte.param;
                    link_pkg::fs_x_b:  x_b[wr.index]  <= wr_byte.param;
                    link_pkg::fs_y_op: y_op[wr.index] <= wr_byte.instr.op;
                    link_pkg::fs_y_a:  y_a[wr.index]  <= wr_byte.param;
                    link_pkg::fs_y_b:  y_b[wr.index]  <= wr_byte.param;
                    default: ;
                endcase
            end
        end
    end

    // same-cycle slot lookup
    assign x_rd.opcode  = x_op[x_rd.index];
    assign x_rd.param_a = x_a[x_rd.index];
    assign x_rd.param_b = x_b[x_rd.index];
    assign y_rd.opcode  = y_op[y_rd.index];
    assign y_rd.param_a = y_a[y_rd.index];
    assign y_rd.param_b = y_b[y_rd.index];

endmodule

`default_nettype wire

//--- src/packet_parser.sv
// packet parser: frames sync, field, data and end bytes into program writes
`timescale 1ns/1ps
`default_nettype none

`include "wave_consts.svh"

module packet_parser (
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    prog_write_if.writer wr
);
    localparam int IDX_W = $clog2(`PROG_DEPTH);

    link_pkg::parse_state_e state;
    logic [IDX_W-1:0]       idx;     // slot of the next data byte

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= link_pkg::ps_idle;
            idx       <= '0;
            wr.wr_en  <= 1'b0;
            wr.commit <= 1'b0;
        end else begin
            // strobes last one cycle
            wr.wr_en  <= 1'b0;
            wr.commit <= 1'b0;
            if (byte_valid) begin
                case (state)
                    link_pkg::ps_idle: begin
                        if (byte_data == `SYNC_BYTE) state <= link_pkg::ps_type;
                    end
                    link_pkg::ps_type: begin
                        wr.field <= link_pkg::field_sel_e'(byte_data[2:0]);
                        idx      <= '0;
                        state    <= link_pkg::ps_data;
                    end
                    link_pkg::ps_data: begin
                        wr.wr_en <= 1'b1;
                        wr.index <= idx;
                        wr.data  <= byte_data;
                        idx      <= idx + 1'b1;
                        if (idx == IDX_W'(`PROG_DEPTH - 1)) state <= link_pkg::ps_end;
                    end
                    link_pkg::ps_end: begin
                        // a bad end byte just drops back to hunting
                        if (byte_data == `END_BYTE) wr.commit <= 1'b1;
                        state <= link_pkg::ps_idle;
                    end
                    default: state <= link_pkg::ps_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
// uart receiver: baud tick generator, input synchronizer and filter, 8N1 byte receiver
`timescale 1ns/1ps
`default_nettype none

`include "wave_consts.svh"

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data
);
    localparam int     ACC_W   = 16;
    localparam int     OS_W    = $clog2(`OVERSAMPLE);
    localparam longint ACC_INC = ((longint'(`BAUD) * `OVERSAMPLE) << ACC_W) / `CLK_FREQ;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

    logic [ACC_W:0]  acc;
    logic            tick;
    logic [1:0]      rx_sync;
    logic [1:0]      filt_cnt;
    logic            rx_bit;
    rx_state_e       state;
    logic [OS_W-1:0] os_cnt;
    logic [2:0]      bit_cnt;
    logic            sample_now;

    // fractional accumulator, carry out is the oversampling tick
    always_ff @(posedge clk) begin
        if (reset) acc <= '0;
        else       acc <= {1'b0, acc[ACC_W-1:0]} + ACC_INC[ACC_W:0];
    end
    assign tick = acc[ACC_W];

    // two-flop synchronizer and saturating 2-bit filter, idle high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync  <= 2'b11;
            filt_cnt <= 2'b11;
            rx_bit   <= 1'b1;
        end else if (tick) begin
            rx_sync <= {rx_sync[0], rx};
            if (rx_sync[1] && filt_cnt != 2'b11)       filt_cnt <= filt_cnt + 2'd1;
            else if (!rx_sync[1] && filt_cnt != 2'b00) filt_cnt <= filt_cnt - 2'd1;
            if (filt_cnt == 2'b11)      rx_bit <= 1'b1;
            else if (filt_cnt == 2'b00) rx_bit <= 1'b0;
        end
    end

    // mid-bit sample point, half a bit after the start edge then every bit
    assign sample_now = tick && (os_cnt == OS_W'(`OVERSAMPLE / 2 - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= rx_idle;
            os_cnt     <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= sample_now && (state == rx_stop) && rx_bit;  // low stop bit drops it
            if (tick) os_cnt <= (state == rx_idle) ? '0 : os_cnt + 1'b1;
            case (state)
                rx_idle:  if (!rx_bit) state <= rx_start;
                rx_start: if (sample_now) begin
                    bit_cnt <= '0;
                    state   <= rx_bit ? rx_idle : rx_data;  // glitch, not a start bit
                end
                rx_data:  if (sample_now) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) state <= rx_stop;
                end
                rx_stop:  if (sample_now) state <= rx_idle;
                default:  state <= rx_idle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (sample_now && state == rx_data) byte_data <= {rx_bit, byte_data[7:1]};
    end

endmodule

`default_nettype wire

//--- src/prog_if.sv
// program write interface and program read interface with their modports
`timescale 1ns/1ps
`default_nettype none

`include "wave_consts.svh"

//////////////////////////////////////////////////
// parser to store, one strobe per data byte

interface prog_write_if;
    localparam int IDX_W = $clog2(`PROG_DEPTH);

    logic                   wr_en;     // one cycle per data byte
    link_pkg::field_sel_e   field;
    logic [IDX_W-1:0]       index;
    logic [7:0]             data;
    logic                   commit;    // end byte seen

    modport writer (output wr_en, field, index, data, commit);
    modport store  (input  wr_en, field, index, data, commit);
endinterface

//////////////////////////////////////////////////
// engine to store, combinational slot lookup

interface prog_read_if;
    localparam int IDX_W = $clog2(`PROG_DEPTH);

    logic [IDX_W-1:0]       index;
    wave_pkg::opcode_e      opcode;
    logic [7:0]             param_a;
    logic [7:0]             param_b;

    modport engine (output index, input  opcode, param_a, param_b);
    modport store  (input  index, output opcode, param_a, param_b);
endinterface

`default_nettype wire

//--- src/link_pkg.sv
// serial link types: packet field selector and parser state
`default_nettype none

package link_pkg;

    // which program array a packet fills
    typedef enum logic [2:0] {
        fs_none = 3'd0,     // parsed, nothing written
        fs_x_op = 3'd1,
        fs_x_a  = 3'd2,
        fs_x_b  = 3'd3,
        fs_y_op = 3'd4,
        fs_y_a  = 3'd5,
        fs_y_b  = 3'd6
    } field_sel_e;

    // packet framing states
    typedef enum logic [1:0] {
        ps_idle = 2'd0,     // hunting for sync
        ps_type = 2'd1,     // next byte is the field selector
        ps_data = 2'd2,
        ps_end  = 2'd3
    } parse_state_e;

endpackage

`default_nettype wire

//--- src/wave_pkg.sv
// waveform types: opcode, sequencer phase and program byte union
`default_nettype none

package wave_pkg;

    // instruction set of a step sequencer
    typedef enum logic [2:0] {
        op_nop    = 3'd0,
        op_line   = 3'd1,
        op_incr   = 3'd2,
        op_dcre   = 3'd3,
        op_jump   = 3'd4,
        op_x_rect = 3'd5,
        op_y_rect = 3'd6
    } opcode_e;

    // sub-step inside one instruction, ph_done holds until ack
    typedef enum logic [2:0] {
        ph_0    = 3'd0,
        ph_1    = 3'd1,
        ph_2    = 3'd2,
        ph_3    = 3'd3,
        ph_done = 3'd4
    } phase_e;

    // one received data byte, read as a parameter or as an opcode
    typedef union packed {
        logic [7:0] param;
        struct packed {
            logic [4:0] pad;     // ignored bits above the opcode
            opcode_e    op;
        } instr;
    } prog_byte_u;

endpackage

`default_nettype wire

//--- src/wave_consts.svh
// clock, serial link and program memory constants for the waveform generator
`ifndef WAVE_CONSTS_SVH
`define WAVE_CONSTS_SVH

//////////////////////////////////////////////////
// clocking and serial link

`define CLK_FREQ   8_000_000     // system clock in Hz
`define BAUD       500_000       // uart bit rate
`define OVERSAMPLE 8             // receiver ticks per bit

//////////////////////////////////////////////////
// program memory and packet framing

`define PROG_DEPTH 8             // instruction slots per channel

// packet markers
`define SYNC_BYTE  8'hAA
`define END_BYTE   8'h55

`endif
